// File: flist.f
rtl/store_pkg.sv
rtl/store_wsel.sv
rtl/byte_wr_ram.sv
rtl/uart_tx.sv
rtl/mmio_regs.sv
rtl/store_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/store_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the store path testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module store_subsys_tb \
    -f flist.f -o store_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/store_sim > sim.log 2>&1

grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
    || { cat sim.log; echo "Simulation failed"; exit 1; }

// File: testbench/store_subsys_tb.sv
`timescale 1ns/100ps

module store_subsys_tb;

    import store_pkg::*;

    localparam int DEPTH        = 256;
    localparam int CLKS_PER_BIT = 8;
    localparam int LED_W        = 8;
    localparam int N_RAND       = 220;
    localparam int N_BAD        = 40;
    localparam int N_IMEM       = 40;
    // Two cycles per store, the fill of both RAMs, a few UART frames, twice over.
    localparam int MAX_CYCLES = 2 * (4 * DEPTH + 2 * (N_RAND + N_BAD + N_IMEM)
                                     + 4 * 10 * CLKS_PER_BIT + 100);

    typedef struct packed {
        logic [3:0]  mask;
        logic [31:0] data;
    } ref_wr_t;

    logic             clk;
    logic             arst_n;
    store_req_t       req;
    logic [29:0]      dmem_raddr;
    logic [29:0]      imem_raddr;
    logic [31:0]      dmem_rdata;
    logic [31:0]      imem_rdata;
    logic             tx;
    logic             uart_busy;
    logic [LED_W-1:0] leds;
    logic [31:0]      cycle_count;

    logic [31:0] dshadow [DEPTH];
    logic [31:0] ishadow [DEPTH];
    logic        rd_valid;
    logic [31:0] rd_d_exp;
    logic [31:0] rd_i_exp;
    logic        chk_valid = 1'b0;
    logic [31:0] chk_d_exp;
    logic [31:0] chk_i_exp;
    logic [31:0] seed;
    int          cycle_no = 0;

    tb_clock_gen #(.HALF_PERIOD(2), .RST_CYCLES(3)) u_clk (.clk(clk), .arst_n(arst_n));

    store_subsys_top #(
        .DMEM_DEPTH  (DEPTH),
        .IMEM_DEPTH  (DEPTH),
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .LED_W       (LED_W)
    ) uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .dmem_raddr (dmem_raddr),
        .imem_raddr (imem_raddr),
        .dmem_rdata (dmem_rdata),
        .imem_rdata (imem_rdata),
        .tx         (tx),
        .uart_busy  (uart_busy),
        .leds       (leds),
        .cycle_count(cycle_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int word_index(input logic [31:0] a);
        return int'(a[31:2] % 30'(DEPTH));
    endfunction

    function automatic store_req_t make_req(input logic [31:0] addr, input logic [31:0] rs2,
                                            input logic [2:0] funct3, input logic pc30);
        store_req_t r;
        r.addr   = addr;
        r.rs2    = rs2;
        r.we     = 1'b1;
        r.funct5 = OPC_STORE_5;
        r.funct3 = funct3;
        r.pc30   = pc30;
        return r;
    endfunction

    // Expected lane data and byte mask of one request.
    function automatic ref_wr_t ref_store(input store_req_t r);
        ref_wr_t    res;
        logic [7:0] src;
        res.mask = 4'b0000;
        res.data = r.rs2;
        if (r.we && r.funct5 == OPC_STORE_5 && r.funct3 <= 3'd2) begin
            for (int b = 0; b < 4; b++) begin
                case (r.funct3)
                    3'd0:    res.mask[b] = (r.addr[1:0] == 2'(b));
                    3'd1:    res.mask[b] = (r.addr[1] == 1'(b / 2));
                    default: res.mask[b] = 1'b1;
                endcase
                if (r.funct3 == 3'd2) src = r.rs2[b*8 +: 8];
                else if (r.funct3 == 3'd1) src = r.rs2[(b % 2)*8 +: 8];
                else src = r.rs2[7:0];
                res.data[b*8 +: 8] = res.mask[b] ? src : 8'h00;
            end
        end
        return res;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic drive_one(input store_req_t r);
        req = r;
        @(negedge clk);
        req = '0;
    endtask

    // Store, then read the same word of both RAMs on the next cycle.
    task automatic do_store(input store_req_t r);
        ref_wr_t w;
        int      idx;
        w   = ref_store(r);
        idx = word_index(r.addr);
        for (int b = 0; b < 4; b++) begin
            if (w.mask[b] && r.addr[DMEM_SEL_BIT]) begin
                dshadow[idx][b*8 +: 8] = w.data[b*8 +: 8];
            end
            if (w.mask[b] && r.addr[IMEM_SEL_BIT] && r.pc30) begin
                ishadow[idx][b*8 +: 8] = w.data[b*8 +: 8];
            end
        end
        drive_one(r);
        dmem_raddr = r.addr[31:2];
        imem_raddr = r.addr[31:2];
        rd_d_exp   = dshadow[idx];
        rd_i_exp   = ishadow[idx];
        rd_valid   = 1'b1;
        @(negedge clk);
        rd_valid = 1'b0;
    endtask

    task automatic run_fill();
        logic [31:0] a;
        for (int i = 0; i < DEPTH; i++) begin
            a = 32'h1000_0000 | 32'(i << 2);
            do_store(make_req(a, fill_word(a), FNC_SW, 1'b0));
            a = 32'h2000_0000 | 32'(i << 2);
            do_store(make_req(a, fill_word(a), FNC_SW, 1'b1));
        end
    endtask

    task automatic run_random(input logic [31:0] base, input int count, input logic alt_pc30);
        logic [31:0] a;
        logic [2:0]  f3;
        for (int i = 0; i < count; i++) begin
            seed = lcg_next(seed);
            a    = base | {22'b0, seed[25:16]};
            f3   = (seed[29:28] == 2'd3) ? FNC_SW : {1'b0, seed[29:28]};
            seed = lcg_next(seed);
            do_store(make_req(a, seed, f3, alt_pc30 & 1'(i % 2)));
        end
    endtask

    task automatic run_bad();
        store_req_t  r;
        logic [31:0] a;
        for (int i = 0; i < N_BAD; i++) begin
            seed = lcg_next(seed);
            a    = (i % 2 == 0) ? 32'h1000_0000 : 32'h2000_0000;
            r    = make_req(a | {22'b0, seed[25:16]}, lcg_next(seed), FNC_SW, 1'b1);
            case (i % 3)
                0:       r.we = 1'b0;
                1:       r.funct5 = OPC_STORE_5 ^ {seed[30:27], 1'b1};
                default: r.funct3 = 3'(3 + int'(seed[31:16] % 16'd5));
            endcase
            do_store(r);
        end
    endtask

    task automatic run_uart();
        store_req_t r;
        store_req_t busy_req;
        ref_wr_t    w;
        logic       exp_bit;
        int         n;
        int         k;
        check_val("uart_busy", 32'(uart_busy), 32'h0);
        seed     = lcg_next(seed);
        r        = make_req(32'h8000_0008, seed, FNC_SB, 1'b0);
        w        = ref_store(r);
        busy_req = make_req(32'h8000_0008, ~seed, FNC_SB, 1'b0);
        drive_one(r);
        n = 0;
        while (tx !== 1'b0) begin
            n++;
            if (n > 2 * CLKS_PER_BIT) abort_run("UART start bit never appeared on tx");
            else @(negedge clk);
        end
        for (n = 1; n <= CLKS_PER_BIT / 2 + 9 * CLKS_PER_BIT; n++) begin
            @(negedge clk);
            if (n == 2 * CLKS_PER_BIT + 1) req = busy_req;   // Second byte while busy.
            if (n == 2 * CLKS_PER_BIT + 2) req = '0;
            if (n % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                k       = n / CLKS_PER_BIT;
                exp_bit = (k == 0) ? 1'b0 : (k == 9) ? 1'b1 : w.data[k-1];
                check_val("uart_busy", 32'(uart_busy), 32'h1);
                check_val("tx", 32'(tx), 32'(exp_bit));
            end
        end
        n = 0;
        while (uart_busy) begin
            n++;
            if (n > 2 * CLKS_PER_BIT) abort_run("UART stayed busy after the stop bit");
            else @(negedge clk);
        end
        for (n = 0; n < 12 * CLKS_PER_BIT; n++) begin
            @(negedge clk);
            if (tx !== 1'b1) abort_run("UART sent a frame for a store made while busy");
        end
    endtask

    task automatic run_mmio();
        store_req_t       r;
        ref_wr_t          w;
        logic [31:0]      cnt;
        logic [LED_W-1:0] led_old;
        seed = lcg_next(seed);
        r    = make_req(32'h8000_0030, seed, FNC_SW, 1'b0);
        w    = ref_store(r);
        drive_one(r);
        check_val("leds", 32'(leds), 32'(w.data[LED_W-1:0]));
        r = make_req(32'h8000_0032, ~seed, FNC_SH, 1'b0);   // Upper half, low lanes zero.
        w = ref_store(r);
        drive_one(r);
        check_val("leds", 32'(leds), 32'(w.data[LED_W-1:0]));
        r = make_req(32'h8000_0030, lcg_next(seed), FNC_SB, 1'b0);
        w = ref_store(r);
        drive_one(r);
        check_val("leds", 32'(leds), 32'(w.data[LED_W-1:0]));
        led_old = leds;
        r.rs2   = ~r.rs2;
        r.we    = 1'b0;
        drive_one(r);
        check_val("leds", 32'(leds), 32'(led_old));
        r = make_req(32'h8000_0018, seed, FNC_SW, 1'b0);
        drive_one(r);
        check_val("cycle_count", cycle_count, 32'h0);
        for (int i = 1; i <= 6; i++) begin
            @(negedge clk);
            check_val("cycle_count", cycle_count, 32'(i));
        end
        cnt  = cycle_count;
        r.we = 1'b0;
        drive_one(r);
        check_val("cycle_count", cycle_count, cnt + 32'd1);
    endtask

    // Read data is registered, so the expected value moves one edge along.
    always @(posedge clk) begin
        chk_valid <= rd_valid;
        chk_d_exp <= rd_d_exp;
        chk_i_exp <= rd_i_exp;
    end

    always @(negedge clk) begin
        if (chk_valid) begin
            check_val("dmem_rdata", dmem_rdata, chk_d_exp);
            check_val("imem_rdata", imem_rdata, chk_i_exp);
        end
    end

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
        if (cycle_no >= MAX_CYCLES) abort_run("Timeout: tests did not finish in time");
    end

    initial begin
        req        = '0;
        dmem_raddr = '0;
        imem_raddr = '0;
        rd_valid   = 1'b0;
        rd_d_exp   = '0;
        rd_i_exp   = '0;
        seed       = 32'h73ab;
        @(posedge arst_n);
        @(negedge clk);
        check_val("tx", 32'(tx), 32'h1);
        check_val("uart_busy", 32'(uart_busy), 32'h0);
        check_val("leds", 32'(leds), 32'h0);
        run_fill();
        for (int lane = 0; lane < 4; lane++) begin
            do_store(make_req(32'h1000_0040 + 32'(lane), lcg_next(32'(lane)), FNC_SB, 1'b0));
        end
        do_store(make_req(32'h1000_0080, 32'h1234_abcd, FNC_SH, 1'b0));
        do_store(make_req(32'h1000_0082, 32'h8765_dcba, FNC_SH, 1'b0));
        run_random(32'h1000_0000, N_RAND, 1'b0);
        run_bad();
        run_random(32'h2000_0000, N_IMEM, 1'b1);   // Alternates pc30.
        run_uart();
        run_mmio();
        repeat (2) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 2,
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release on a falling edge, away from the flops' active edge.
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: rtl/store_subsys_top.sv
`timescale 1ns/100ps

module store_subsys_top #(
    parameter int DMEM_DEPTH   = 256,
    parameter int IMEM_DEPTH   = 256,
    parameter int CLKS_PER_BIT = 8,
    parameter int LED_W        = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  store_pkg::store_req_t req,
    input  logic [29:0]           dmem_raddr,
    input  logic [29:0]           imem_raddr,
    output logic [31:0]           dmem_rdata,
    output logic [31:0]           imem_rdata,
    output logic                  tx,
    output logic                  uart_busy,
    output logic [LED_W-1:0]      leds,
    output logic [31:0]           cycle_count
);

    import store_pkg::*;

    mem_wr_t     dmem_wr;
    mem_wr_t     imem_wr;
    logic        uart_we;
    logic [7:0]  uart_data;
    logic        counter_reset;
    logic        leds_we;
    logic [31:0] wdata;

    store_wsel u_wsel (
        .req          (req),
        .dmem_wr      (dmem_wr),
        .imem_wr      (imem_wr),
        .uart_we      (uart_we),
        .uart_data    (uart_data),
        .counter_reset(counter_reset),
        .leds_we      (leds_we),
        .wdata        (wdata)
    );

    byte_wr_ram #(.DEPTH(DMEM_DEPTH)) dmem (
        .clk  (clk),
        .wr   (dmem_wr),
        .raddr(dmem_raddr),
        .rdata(dmem_rdata)
    );

    byte_wr_ram #(.DEPTH(IMEM_DEPTH)) imem (
        .clk  (clk),
        .wr   (imem_wr),
        .raddr(imem_raddr),
        .rdata(imem_rdata)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .clk   (clk),
        .arst_n(arst_n),
        .we    (uart_we),
        .data  (uart_data),
        .tx    (tx),
        .busy  (uart_busy)
    );

    mmio_regs #(.LED_W(LED_W)) u_mmio (
        .clk          (clk),
        .arst_n       (arst_n),
        .leds_we      (leds_we),
        .wdata        (wdata),
        .counter_reset(counter_reset),
        .leds         (leds),
        .cycle_count  (cycle_count)
    );

endmodule

// File: rtl/mmio_regs.sv
`timescale 1ns/100ps

module mmio_regs #(
    parameter int LED_W = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             leds_we,
    input  logic [31:0]      wdata,
    input  logic             counter_reset,
    output logic [LED_W-1:0] leds,
    output logic [31:0]      cycle_count
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;
        end else if (leds_we) begin
            leds <= wdata[LED_W-1:0];
        end
    end

    // Free-running, wraps at 2^32.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_count <= '0;
        end else if (counter_reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
        end
    end

    // A clear shows as zero for exactly one cycle, then counting resumes.
    a_cnt_clear: assert property (
        @(posedge clk) disable iff (!arst_n)
        counter_reset ##1 !counter_reset |=> cycle_count == 32'd1
    ) else $error("mmio_regs: counter did not restart from zero");

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       we,
    input  logic [7:0] data,
    output logic       tx,
    output logic       busy
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [9:0]    frame;      // Stop, data, start; bit 0 is on the line.
    logic [CW-1:0] baud_cnt;
    logic [3:0]    bit_cnt;
    logic          bit_end;

    assign bit_end = baud_cnt == CW'(CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else if (!busy) begin
            if (we) begin
                frame    <= {1'b1, data, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                busy     <= 1'b1;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;   // Stop bit done.
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + CW'(1);
        end
    end

    assign tx = frame[0];

    // Line idles high between frames.
    a_idle_high: assert property (
        @(posedge clk) disable iff (!arst_n) !busy |-> tx
    ) else $error("uart_tx: tx low while idle");

endmodule

// File: rtl/byte_wr_ram.sv
`timescale 1ns/100ps

module byte_wr_ram #(
    parameter int DEPTH = 256
) (
    input  logic               clk,
    input  store_pkg::mem_wr_t wr,
    input  logic [29:0]        raddr,
    output logic [31:0]        rdata
);

    import store_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] widx;
    logic [AW-1:0] ridx;

    // Word address wraps at the depth.
    assign widx = AW'(wr.addr % 30'(DEPTH));
    assign ridx = AW'(raddr % 30'(DEPTH));

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr.wea[b]) begin
                mem[widx][b*8 +: 8] <= wr.data[b*8 +: 8];
            end
        end
    end

    // Read-before-write on a same-word collision.
    always_ff @(posedge clk) begin
        rdata <= mem[ridx];
    end

    // Only a byte, an aligned half or the full word comes from a store.
    a_wr_mask_legal: assert property (
        @(posedge clk) wr.wea inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0011, 4'b1100, 4'b1111}
    ) else $error("byte_wr_ram: illegal byte-enable mask");

endmodule

// File: rtl/store_wsel.sv
`timescale 1ns/100ps

module store_wsel (
    input  store_pkg::store_req_t req,
    output store_pkg::mem_wr_t    dmem_wr,
    output store_pkg::mem_wr_t    imem_wr,
    output logic                  uart_we,
    output logic [7:0]            uart_data,
    output logic                  counter_reset,
    output logic                  leds_we,
    output logic [31:0]           wdata
);

    import store_pkg::*;

    logic [3:0] mask;
    logic       dmem_sel;
    logic       imem_sel;
    logic       mmio_sel;

    // Lane alignment and byte mask.
    always_comb begin
        mask  = 4'b0000;
        wdata = req.rs2;
        if (req.we && req.funct5 == OPC_STORE_5) begin
            case (req.funct3)
                FNC_SB: begin
                    mask  = 4'b0001 << req.addr[1:0];
                    wdata = {24'b0, req.rs2[7:0]} << {req.addr[1:0], 3'b000};
                end
                FNC_SH: begin
                    if (req.addr[1]) begin
                        mask  = 4'b1100;
                        wdata = {req.rs2[15:0], 16'b0};
                    end else begin
                        mask  = 4'b0011;
                        wdata = {16'b0, req.rs2[15:0]};
                    end
                end
                FNC_SW: begin
                    mask = 4'b1111;
                end
                default: ;   // Unsupported width, nothing written.
            endcase
        end
    end

    assign dmem_sel = req.addr[DMEM_SEL_BIT];
    assign imem_sel = req.addr[IMEM_SEL_BIT] && req.pc30;
    assign mmio_sel = req.addr[MMIO_SEL_BIT];

    assign dmem_wr.addr = req.addr[31:2];
    assign dmem_wr.data = wdata;
    assign dmem_wr.wea  = dmem_sel ? mask : 4'b0000;

    assign imem_wr.addr = req.addr[31:2];
    assign imem_wr.data = wdata;
    assign imem_wr.wea  = imem_sel ? mask : 4'b0000;

    assign uart_we   = mmio_sel && req.addr[5:3] == MMIO_UART_TX && mask[0];
    assign uart_data = wdata[7:0];

    // Strobes only fire on a real store.
    assign counter_reset = mmio_sel && req.addr[5:3] == MMIO_CNT_RST && |mask;
    assign leds_we       = mmio_sel && req.addr[5:3] == MMIO_LEDS && |mask;

    // One store reaches one target only; overlapping region bits are a map error.
    always_comb begin
        assert final ($onehot0({|dmem_wr.wea, |imem_wr.wea, uart_we,
                                counter_reset, leds_we}))
            else $error("store_wsel: store hits more than one target");
    end

endmodule

// File: rtl/store_pkg.sv
package store_pkg;

    // Opcode field of a store, funct5 of the instruction.
    localparam logic [4:0] OPC_STORE_5 = 5'b01000;

    // Store widths, funct3.
    localparam logic [2:0] FNC_SB = 3'd0;
    localparam logic [2:0] FNC_SH = 3'd1;
    localparam logic [2:0] FNC_SW = 3'd2;

    // MMIO register select, addr[5:3].
    localparam logic [2:0] MMIO_UART_TX = 3'b001;
    localparam logic [2:0] MMIO_CNT_RST = 3'b011;
    localparam logic [2:0] MMIO_LEDS    = 3'b110;

    // Region select bits of the address.
    localparam int DMEM_SEL_BIT = 28;
    localparam int IMEM_SEL_BIT = 29;
    localparam int MMIO_SEL_BIT = 31;

    // Store request as seen at the end of execute.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] rs2;
        logic        we;
        logic [4:0]  funct5;
        logic [2:0]  funct3;
        logic        pc30;   // Set while running from a PC that may write imem.
    } store_req_t;

    // Byte-enable write port of a word RAM.
    typedef struct packed {
        logic [29:0] addr;   // Word address.
        logic [31:0] data;
        logic [3:0]  wea;
    } mem_wr_t;

endpackage
